/* source/edge_pkg.sv */
`default_nettype none

package edge_pkg;

    // One grayscale magnitude
    typedef logic [7:0] pixel_t;

    // Classified pixel as it leaves the hysteresis stage
    typedef struct packed {
        pixel_t pixel;
        // Set on the final pixel of a frame
        logic   last;
    } highlight_t;

    // Default frame size
    localparam int default_width  = 8;
    localparam int default_height = 6;

    // Default hysteresis thresholds, both compared strictly
    localparam pixel_t default_high_threshold = 8'd48;
    localparam pixel_t default_low_threshold  = 8'd12;

endpackage

`default_nettype wire

/* source/pixel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
    parameter type payload_t = edge_pkg::pixel_t,
    parameter int  depth     = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   do_write;
    logic                   do_read;

    // Wrap at depth so non power of two sizes work
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign full  = (count == count_width'(depth));
    assign empty = (count == '0);

    // Head of the queue is visible without a read strobe
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer and consumer must respect the level flags
    assert property (@(posedge clock) disable iff (reset) wr_en |-> !full)
        else $error("pixel_fifo: write while full");

    assert property (@(posedge clock) disable iff (reset) rd_en |-> !empty)
        else $error("pixel_fifo: read while empty");

endmodule

`default_nettype wire

/* source/frame_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_bram #(
    parameter int depth = 48
) (
    input  logic                     clock,
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  edge_pkg::pixel_t         wr_data,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output edge_pkg::pixel_t         rd_data
);

    edge_pkg::pixel_t mem [depth];

    // Write port
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* source/hysteresis.sv */
`timescale 1ns/1ps
`default_nettype none

module hysteresis #(
    parameter int               width          = edge_pkg::default_width,
    parameter int               height         = edge_pkg::default_height,
    parameter edge_pkg::pixel_t high_threshold = edge_pkg::default_high_threshold,
    parameter edge_pkg::pixel_t low_threshold  = edge_pkg::default_low_threshold
) (
    input  logic                              clock,
    input  logic                              reset,

    // Input pixel FIFO with first word fall through
    output logic                              in_rd_en,
    input  logic                              in_empty,
    input  edge_pkg::pixel_t                  in_dout,

    // Frame memory
    output logic                              bram_wr_en,
    output logic [$clog2(width*height)-1:0]   bram_wr_addr,
    output edge_pkg::pixel_t                  bram_wr_data,
    output logic [$clog2(width*height)-1:0]   bram_rd_addr,
    input  edge_pkg::pixel_t                  bram_rd_data,

    // Highlight FIFO
    output edge_pkg::highlight_t              highlight_din,
    output logic                              highlight_wr_en,
    input  logic                              highlight_full,

    output logic                              hough_start
);

    localparam int frame_size = width * height;
    localparam int addr_width = $clog2(frame_size);
    localparam int shift_len  = 2 * width + 3;
    // Last centre position that still pulls a real pixel from the FIFO
    localparam int last_fetch = frame_size - width - 3;

    typedef enum logic [2:0] {
        s_idle,
        s_prologue,
        s_hysteresis,
        s_output,
        s_select_addr,
        s_read
    } state_t;

    state_t state;
    state_t next_state;

    logic [$clog2(width + 2)-1:0] counter;
    logic [$clog2(width + 2)-1:0] counter_c;
    logic [$clog2(width)-1:0]     col;
    logic [$clog2(width)-1:0]     col_c;
    logic [$clog2(height)-1:0]    row;
    logic [$clog2(height)-1:0]    row_c;

    // Index 0 holds the oldest pixel and new pixels enter at the top
    edge_pkg::pixel_t [shift_len-1:0] shift_reg;
    edge_pkg::pixel_t [8:0]           window;
    edge_pkg::pixel_t                 shift_in;
    edge_pkg::pixel_t                 classified;
    edge_pkg::pixel_t                 result;

    logic [addr_width-1:0] pixel_addr;
    logic                  shift_en;
    logic                  exhausted;
    logic                  at_border;
    logic                  last_pixel;
    logic                  strong_near;

    assign pixel_addr = addr_width'(row * width + col);
    assign exhausted  = (pixel_addr > last_fetch);
    assign last_pixel = (row == height - 1) && (col == width - 1);
    assign at_border  = (row == 0) || (row == height - 1) || (col == 0) || (col == width - 1);

    // 3x3 window with its centre at index 4
    assign window[0] = shift_reg[0];
    assign window[1] = shift_reg[1];
    assign window[2] = shift_reg[2];
    assign window[3] = shift_reg[width];
    assign window[4] = shift_reg[width + 1];
    assign window[5] = shift_reg[width + 2];
    assign window[6] = shift_reg[2 * width];
    assign window[7] = shift_reg[2 * width + 1];
    assign window[8] = shift_reg[2 * width + 2];

    always_comb begin
        strong_near = 1'b0;
        for (int i = 0; i < 9; i++) begin
            if (i != 4 && window[i] > high_threshold) begin
                strong_near = 1'b1;
            end
        end
    end

    // Strong pixels pass and weak ones only next to a strong neighbour
    always_comb begin
        classified = '0;
        if (!at_border) begin
            if (window[4] > high_threshold ||
                (window[4] > low_threshold && strong_near)) begin
                classified = window[4];
            end
        end
    end

    // Zero padding once the frame has been fully read
    assign shift_in = (state == s_hysteresis && exhausted) ? '0 : in_dout;

    always_comb begin
        next_state      = state;
        counter_c       = counter;
        row_c           = row;
        col_c           = col;
        in_rd_en        = 1'b0;
        shift_en        = 1'b0;
        bram_wr_en      = 1'b0;
        highlight_wr_en = 1'b0;
        hough_start     = 1'b0;

        case (state)
            s_idle: begin
                next_state = s_prologue;
            end

            // Fill the window with width+2 pixels
            s_prologue: begin
                if (!in_empty) begin
                    in_rd_en  = 1'b1;
                    shift_en  = 1'b1;
                    counter_c = counter + 1'b1;
                    if (counter == width + 1) begin
                        next_state = s_hysteresis;
                    end
                end
            end

            s_hysteresis: begin
                if (exhausted || !in_empty) begin
                    shift_en   = 1'b1;
                    in_rd_en   = !exhausted;
                    next_state = s_output;
                end
            end

            s_output: begin
                bram_wr_en = 1'b1;
                next_state = s_select_addr;
            end

            s_select_addr: begin
                next_state = s_read;
            end

            // Stays here while the highlight FIFO is full
            s_read: begin
                if (!highlight_full) begin
                    highlight_wr_en = 1'b1;
                    next_state      = s_hysteresis;
                    if (last_pixel) begin
                        hough_start = 1'b1;
                        row_c       = '0;
                        col_c       = '0;
                        counter_c   = '0;
                        next_state  = s_idle;
                    end else if (col == width - 1) begin
                        col_c = '0;
                        row_c = row + 1'b1;
                    end else begin
                        col_c = col + 1'b1;
                    end
                end
            end

            default: begin
                next_state = s_prologue;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= s_prologue;
            counter <= '0;
            row     <= '0;
            col     <= '0;
        end else begin
            state   <= next_state;
            counter <= counter_c;
            row     <= row_c;
            col     <= col_c;
        end
    end

    // Classify from the window before it moves on
    always_ff @(posedge clock) begin
        if (shift_en) begin
            shift_reg <= {shift_in, shift_reg[shift_len-1:1]};
        end
        if (state == s_hysteresis && shift_en) begin
            result <= classified;
        end
    end

    assign bram_wr_addr = pixel_addr;
    assign bram_wr_data = result;

    // Address held through READ so a stalled push still sees valid data
    assign bram_rd_addr = (state == s_select_addr || state == s_read) ? pixel_addr : '0;

    assign highlight_din = '{pixel: bram_rd_data, last: last_pixel};

    // A full highlight FIFO holds the pending push with unchanged data
    assert property (@(posedge clock) disable iff (reset)
        state == s_read && highlight_full |=> state == s_read && $stable(highlight_din))
        else $error("hysteresis: highlight push not held while FIFO full");

    // Frame memory returns the written value when READ begins
    assert property (@(posedge clock) disable iff (reset)
        bram_wr_en |-> ##2 (state == s_read && bram_rd_data == $past(bram_wr_data, 2)))
        else $error("hysteresis: frame memory readback mismatch");

endmodule

`default_nettype wire

/* source/edge_hysteresis_top.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_hysteresis_top #(
    parameter int               width          = edge_pkg::default_width,
    parameter int               height         = edge_pkg::default_height,
    parameter edge_pkg::pixel_t high_threshold = edge_pkg::default_high_threshold,
    parameter edge_pkg::pixel_t low_threshold  = edge_pkg::default_low_threshold,
    parameter int               fifo_depth     = 4
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 pixel_wr_en,
    input  edge_pkg::pixel_t     pixel_in,
    output logic                 pixel_full,
    input  logic                 highlight_rd_en,
    output edge_pkg::highlight_t highlight_out,
    output logic                 highlight_empty,
    output logic                 hough_start
);

    localparam int frame_size = width * height;
    localparam int addr_width = $clog2(frame_size);

    logic                  in_rd_en;
    logic                  in_empty;
    edge_pkg::pixel_t      in_dout;

    logic                  bram_wr_en;
    logic [addr_width-1:0] bram_wr_addr;
    edge_pkg::pixel_t      bram_wr_data;
    logic [addr_width-1:0] bram_rd_addr;
    edge_pkg::pixel_t      bram_rd_data;

    edge_pkg::highlight_t  highlight_din;
    logic                  highlight_wr_en;
    logic                  highlight_full;

    // Incoming grayscale stream
    pixel_fifo #(
        .payload_t (edge_pkg::pixel_t),
        .depth     (fifo_depth)
    ) input_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (pixel_wr_en),
        .din   (pixel_in),
        .full  (pixel_full),
        .rd_en (in_rd_en),
        .dout  (in_dout),
        .empty (in_empty)
    );

    hysteresis #(
        .width          (width),
        .height         (height),
        .high_threshold (high_threshold),
        .low_threshold  (low_threshold)
    ) hysteresis_inst (
        .clock           (clock),
        .reset           (reset),
        .in_rd_en        (in_rd_en),
        .in_empty        (in_empty),
        .in_dout         (in_dout),
        .bram_wr_en      (bram_wr_en),
        .bram_wr_addr    (bram_wr_addr),
        .bram_wr_data    (bram_wr_data),
        .bram_rd_addr    (bram_rd_addr),
        .bram_rd_data    (bram_rd_data),
        .highlight_din   (highlight_din),
        .highlight_wr_en (highlight_wr_en),
        .highlight_full  (highlight_full),
        .hough_start     (hough_start)
    );

    frame_bram #(
        .depth (frame_size)
    ) frame_mem (
        .clock   (clock),
        .wr_en   (bram_wr_en),
        .wr_addr (bram_wr_addr),
        .wr_data (bram_wr_data),
        .rd_addr (bram_rd_addr),
        .rd_data (bram_rd_data)
    );

    // Classified stream towards the line detector
    pixel_fifo #(
        .payload_t (edge_pkg::highlight_t),
        .depth     (fifo_depth)
    ) highlight_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (highlight_wr_en),
        .din   (highlight_din),
        .full  (highlight_full),
        .rd_en (highlight_rd_en),
        .dout  (highlight_out),
        .empty (highlight_empty)
    );

endmodule

`default_nettype wire

/* test/hysteresis_vectors.svh */
`ifndef hysteresis_vectors_svh
`define hysteresis_vectors_svh

// Content of one test frame
typedef enum logic [2:0] {
    pat_ramp,
    pat_spot,
    pat_ring,
    pat_weak,
    pat_random
} pattern_t;

// One frame: pattern, input gap and drain stall chances in percent
typedef struct packed {
    pattern_t   kind;
    logic [7:0] gap_pct;
    logic [7:0] stall_pct;
} frame_row_t;

typedef edge_pkg::pixel_t [frame_pixels-1:0] frame_t;

localparam int num_frames = 7;

localparam frame_row_t frame_table [num_frames] = '{
    '{kind: pat_ramp,   gap_pct: 8'd0,  stall_pct: 8'd0},
    '{kind: pat_spot,   gap_pct: 8'd30, stall_pct: 8'd0},
    '{kind: pat_ring,   gap_pct: 8'd0,  stall_pct: 8'd80},
    '{kind: pat_weak,   gap_pct: 8'd50, stall_pct: 8'd50},
    '{kind: pat_random, gap_pct: 8'd20, stall_pct: 8'd85},
    '{kind: pat_random, gap_pct: 8'd60, stall_pct: 8'd10},
    '{kind: pat_ramp,   gap_pct: 8'd10, stall_pct: 8'd70}
};

// Expected output for one pixel, straight from the hysteresis rule
function automatic edge_pkg::pixel_t reference_pixel(input frame_t img, input int r, input int c);
    edge_pkg::pixel_t centre;
    bit               strong_neighbour;
    int               dr;
    int               dc;
    strong_neighbour = 1'b0;
    if (r == 0 || r == frame_height - 1 || c == 0 || c == frame_width - 1) begin
        return '0;
    end
    centre = img[r * frame_width + c];
    for (dr = -1; dr <= 1; dr++) begin
        for (dc = -1; dc <= 1; dc++) begin
            if ((dr != 0 || dc != 0) &&
                img[(r + dr) * frame_width + c + dc] > high_level) begin
                strong_neighbour = 1'b1;
            end
        end
    end
    if (centre > high_level) begin
        return centre;
    end
    if (centre > low_level && strong_neighbour) begin
        return centre;
    end
    return '0;
endfunction

`endif

/* test/edge_hysteresis_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_hysteresis_tb;

    localparam int frame_width  = 8;
    localparam int frame_height = 6;
    localparam int frame_pixels = frame_width * frame_height;
    localparam int high_level   = 48;
    localparam int low_level    = 12;

    `include "hysteresis_vectors.svh"

    localparam int cycle_limit = num_frames * frame_pixels * 16 + 200;

    logic                 clock;
    logic                 reset;
    logic                 pixel_wr_en;
    edge_pkg::pixel_t     pixel_in;
    logic                 pixel_full;
    logic                 highlight_rd_en;
    edge_pkg::highlight_t highlight_out;
    logic                 highlight_empty;
    logic                 hough_start;

    frame_t frames [num_frames];
    int     error_count     = 0;
    int     start_count     = 0;
    int     highlight_count = 0;
    int     cycle_count     = 0;

    edge_hysteresis_top #(
        .width          (frame_width),
        .height         (frame_height),
        .high_threshold (8'(high_level)),
        .low_threshold  (8'(low_level)),
        .fifo_depth     (4)
    ) uut (
        .clock           (clock),
        .reset           (reset),
        .pixel_wr_en     (pixel_wr_en),
        .pixel_in        (pixel_in),
        .pixel_full      (pixel_full),
        .highlight_rd_en (highlight_rd_en),
        .highlight_out   (highlight_out),
        .highlight_empty (highlight_empty),
        .hough_start     (hough_start)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Pulses seen so far, over all frames
    always @(posedge clock) begin
        if (!reset && hough_start === 1'b1) begin
            start_count <= start_count + 1;
        end
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: no result after %0d cycles, %0d highlights received",
                 cycle_limit, highlight_count);
        $display("Test failures found");
        $finish;
    end

    task automatic check_pixel(input string name, input edge_pkg::pixel_t expected,
                               input edge_pkg::pixel_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_last(input string name, input bit expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s expected %0b, actual %0b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_start_count(input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("** Error at %0t: hough_start pulse count expected %0d, actual %0d",
                     $time, expected, actual);
        end
    endtask

    // 3x3 block around the ring centre at row 3, column 4
    function automatic edge_pkg::pixel_t ring_value(input int k);
        case (k)
            0: return 8'd13;
            1: return 8'd12;
            2: return 8'd48;
            3: return 8'd30;
            4: return 8'd90;
            5: return 8'd47;
            6: return 8'd25;
            7: return 8'd12;
            default: return 8'd40;
        endcase
    endfunction

    task automatic fill_frames();
        int f;
        int idx;
        int r;
        int c;
        for (f = 0; f < num_frames; f++) begin
            for (idx = 0; idx < frame_pixels; idx++) begin
                r = idx / frame_width;
                c = idx % frame_width;
                case (frame_table[f].kind)
                    pat_ramp: frames[f][idx] = 8'((r * 37 + c * 11 + f * 3) % 256);
                    pat_spot: begin
                        frames[f][idx] = 8'(6 + idx % 5);
                        if (r == 2 && c == 3) frames[f][idx] = 8'd160;
                        // Weak pixel touching the spot, and one that does not
                        if (r == 3 && c == 4) frames[f][idx] = 8'd25;
                        if (r == 3 && c == 6) frames[f][idx] = 8'd30;
                    end
                    pat_ring: begin
                        frames[f][idx] = 8'd20;
                        // Strong top border lifts the weak row below it
                        if (r == 0) frames[f][idx] = 8'd200;
                        if (r >= 2 && r <= 4 && c >= 3 && c <= 5) begin
                            frames[f][idx] = ring_value((r - 2) * 3 + (c - 3));
                        end
                    end
                    pat_weak: frames[f][idx] = 8'(13 + (idx * 7 + f) % 36);
                    default:  frames[f][idx] = 8'($urandom % 120);
                endcase
            end
        end
    endtask

    // Writes alternate with idle cycles so the full flag seen is never stale
    task automatic write_frames();
        int f;
        int i;
        for (f = 0; f < num_frames; f++) begin
            i = 0;
            while (i < frame_pixels) begin
                @(posedge clock);
                if (pixel_wr_en) begin
                    pixel_wr_en <= 1'b0;
                end else if (!pixel_full && ($urandom % 100) >= frame_table[f].gap_pct) begin
                    pixel_wr_en <= 1'b1;
                    pixel_in    <= frames[f][i];
                    i++;
                end
            end
        end
        @(posedge clock);
        pixel_wr_en <= 1'b0;
    endtask

    task automatic read_frames();
        int                   f;
        int                   j;
        bit                   got;
        edge_pkg::highlight_t item;
        string                where;
        for (f = 0; f < num_frames; f++) begin
            for (j = 0; j < frame_pixels; j++) begin
                got = 1'b0;
                while (!got) begin
                    @(posedge clock);
                    if (highlight_rd_en) begin
                        // Pop happens at this edge, head value is the popped item
                        item = highlight_out;
                        highlight_rd_en <= 1'b0;
                        got = 1'b1;
                    end else if (!highlight_empty &&
                                 ($urandom % 100) >= frame_table[f].stall_pct) begin
                        highlight_rd_en <= 1'b1;
                    end
                end
                highlight_count++;
                where = $sformatf("frame %0d row %0d col %0d", f, j / frame_width,
                                  j % frame_width);
                check_pixel({"highlight_out.pixel ", where},
                            reference_pixel(frames[f], j / frame_width, j % frame_width),
                            item.pixel);
                check_last({"highlight_out.last ", where}, j == frame_pixels - 1, item.last);
                if (j == frame_pixels - 1) begin
                    check_start_count(f + 1, start_count);
                end
            end
        end
    endtask

    initial begin
        reset           = 1'b1;
        pixel_wr_en     = 1'b0;
        pixel_in        = '0;
        highlight_rd_en = 1'b0;
        void'($urandom(32'he7b9_1083));
        fill_frames();

        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check_last("pixel_full after reset", 1'b0, pixel_full);
        check_last("highlight_empty after reset", 1'b1, highlight_empty);
        check_last("hough_start after reset", 1'b0, hough_start);

        fork
            write_frames();
            read_frames();
        join

        // Nothing extra may follow the last frame
        repeat (8) @(posedge clock);
        check_last("highlight_empty at end", 1'b1, highlight_empty);
        check_start_count(num_frames, start_count);

        $display("Summary: %0d errors over %0d frames and %0d highlights in %0d cycles",
                 error_count, num_frames, highlight_count, cycle_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* edge_hysteresis_top.f */
+incdir+test
source/edge_pkg.sv
source/pixel_fifo.sv
source/frame_bram.sv
source/hysteresis.sv
source/edge_hysteresis_top.sv
test/edge_hysteresis_tb.sv

/* Bender.yml */
package:
  name: edge_hysteresis

sources:
  # Design sources in compile order
  - files:
      - source/edge_pkg.sv
      - source/pixel_fifo.sv
      - source/frame_bram.sv
      - source/hysteresis.sv
      - source/edge_hysteresis_top.sv

  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/edge_hysteresis_tb.sv
